// File: verilog/bus_pkg.sv
package bus_pkg;

  typedef logic [31:0] addr_t;   // byte address
  typedef logic [31:0] data_t;   // one bus word
  typedef logic [3:0]  strb_t;   // one enable per byte lane
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;
  localparam resp_t RESP_DECERR = 2'd3;

  // write address, data and strobe share one channel
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } write_req_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } read_resp_t;

  // request as handed from the decoder to a slave
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
    logic  is_write;
  } bus_req_t;

  // what a slave reports back when it is done
  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  is_write;
  } exec_result_t;

endpackage

// File: verilog/soc_map_pkg.sv
package soc_map_pkg;

  typedef logic [1:0]  region_t;
  typedef logic [19:0] lfsr_t;

  localparam region_t REGION_SRAM = 2'd0;
  localparam region_t REGION_UART = 2'd1;
  localparam region_t REGION_NONE = 2'd2;  // unmapped and answered with DECERR

  localparam logic [31:0] SRAM_BASE  = 32'h8000_0000;
  localparam int          SRAM_WORDS = 256;  // 1 KiB window

  localparam logic [31:0] UART_BASE       = 32'h1000_0000;
  localparam logic [31:0] UART_TX_OFS     = 32'd0;
  localparam logic [31:0] UART_STATUS_OFS = 32'd4;

  // seeds must be non-zero or the lfsr locks up
  localparam lfsr_t SRAM_LFSR_SEED = 20'h0_0065;
  localparam lfsr_t UART_LFSR_SEED = 20'h5_a3c1;

  localparam logic STALL_EN = 1'b1;

endpackage

// File: verilog/bus_decode.sv
module bus_decode (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                ar_valid_i,
  input  bus_pkg::addr_t      ar_addr_i,
  output logic                ar_ready_o,
  input  logic                aw_valid_i,
  input  bus_pkg::write_req_t aw_req_i,
  output logic                aw_ready_o,
  output bus_pkg::bus_req_t   req_o,
  output logic                sram_go_o,
  output logic                uart_go_o,
  input  logic                sram_done_i,
  input  logic                uart_done_i,
  output logic                decerr_o,
  input  logic                resp_done_i
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  typedef enum logic [1:0] {IDLE, DISPATCH, WAIT_RESP} state_e;

  state_e  state_q;
  region_t region_q;
  region_t sel_region;
  addr_t   sel_addr;
  logic    take_rd;
  logic    take_wr;

  assign ar_ready_o = (state_q == IDLE);
  assign aw_ready_o = (state_q == IDLE) && !ar_valid_i;  // read wins a tie
  assign take_rd    = ar_valid_i && ar_ready_o;
  assign take_wr    = aw_valid_i && aw_ready_o;
  assign sel_addr   = take_rd ? ar_addr_i : aw_req_i.addr;

  always_comb begin
    if (sel_addr >= SRAM_BASE && sel_addr < SRAM_BASE + addr_t'(SRAM_WORDS * 4)) begin
      sel_region = REGION_SRAM;
    end else if (sel_addr >= UART_BASE && sel_addr < UART_BASE + UART_STATUS_OFS + 4) begin
      sel_region = REGION_UART;
    end else begin
      sel_region = REGION_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (take_rd || take_wr) begin
            state_q <= DISPATCH;
          end
        end
        DISPATCH: begin
          // an unmapped request only needs the single error pulse
          if (region_q == REGION_NONE || sram_done_i || uart_done_i) begin
            state_q <= WAIT_RESP;
          end
        end
        default: begin
          if (resp_done_i) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_rd || take_wr) begin
      req_o.addr     <= sel_addr;
      req_o.data     <= take_rd ? '0 : aw_req_i.data;
      req_o.strb     <= take_rd ? '0 : aw_req_i.strb;
      req_o.is_write <= !take_rd;
      region_q       <= sel_region;
    end
  end

  assign sram_go_o = (state_q == DISPATCH) && (region_q == REGION_SRAM);
  assign uart_go_o = (state_q == DISPATCH) && (region_q == REGION_UART);
  assign decerr_o  = (state_q == DISPATCH) && (region_q == REGION_NONE);

endmodule

// File: verilog/sram_slave.sv
module sram_slave (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  go_i,
  input  bus_pkg::bus_req_t     req_i,
  output logic                  done_o,
  output bus_pkg::exec_result_t result_o
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  data_t      mem [SRAM_WORDS];
  lfsr_t      lfsr_q;
  logic       accept;
  logic [7:0] idx;

  assign idx = req_i.addr[9:2];  // word index inside the window

  // done_o blocks a second accept while the decoder still holds go
  assign accept = go_i && !done_o && (lfsr_q[19] || !STALL_EN);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lfsr_q <= SRAM_LFSR_SEED;
      done_o <= 1'b0;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};  // x^20 + x^17 + 1
      done_o <= accept;
    end
  end

  // byte lanes are written independently
  always_ff @(posedge clk) begin
    if (accept && req_i.is_write) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.strb[b]) begin
          mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result_o.is_write <= req_i.is_write;
      result_o.resp     <= RESP_OKAY;
      if (req_i.is_write) begin
        result_o.data <= '0;
      end else begin
        result_o.data <= mem[idx];  // stored word as no write happens on a read
      end
    end
  end

endmodule

// File: verilog/uart_slave.sv
module uart_slave (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  go_i,
  input  bus_pkg::bus_req_t     req_i,
  output logic                  done_o,
  output bus_pkg::exec_result_t result_o,
  output logic                  tx_valid_o,
  output logic [7:0]            tx_byte_o
);
  import bus_pkg::*;
  import soc_map_pkg::*;

  lfsr_t      lfsr_q;
  addr_t      ofs;
  logic       is_tx;
  logic       accept;
  logic       tx_write;
  logic [7:0] tx_count_q;

  assign ofs      = {req_i.addr[31:2], 2'b00} - UART_BASE;
  assign is_tx    = (ofs == UART_TX_OFS);  // anything else in the window is status
  assign accept   = go_i && !done_o && (lfsr_q[19] || !STALL_EN);
  assign tx_write = accept && req_i.is_write && is_tx;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lfsr_q     <= UART_LFSR_SEED;
      done_o     <= 1'b0;
      tx_valid_o <= 1'b0;
      tx_count_q <= 8'd0;
    end else begin
      lfsr_q     <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
      done_o     <= accept;
      tx_valid_o <= tx_write;  // one strobe per tx write
      if (tx_write) begin
        tx_count_q <= tx_count_q + 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_write) begin
      tx_byte_o <= req_i.data[7:0];
    end
    if (accept) begin
      result_o.is_write <= req_i.is_write;
      if (req_i.is_write) begin
        result_o.data <= '0;
        result_o.resp <= is_tx ? RESP_OKAY : RESP_SLVERR;  // status is read-only
      end else begin
        result_o.data <= is_tx ? '0 : data_t'(tx_count_q);
        result_o.resp <= RESP_OKAY;
      end
    end
  end

endmodule

// File: verilog/bus_response.sv
module bus_response (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  sram_done_i,
  input  logic                  uart_done_i,
  input  bus_pkg::exec_result_t sram_result_i,
  input  bus_pkg::exec_result_t uart_result_i,
  input  logic                  decerr_i,
  input  logic                  decerr_write_i,
  output logic                  r_valid_o,
  output bus_pkg::read_resp_t   r_resp_o,
  input  logic                  r_ready_i,
  output logic                  b_valid_o,
  output bus_pkg::resp_t        b_resp_o,
  input  logic                  b_ready_i,
  output logic                  resp_done_o
);
  import bus_pkg::*;

  exec_result_t res_d;
  exec_result_t res_q;
  logic         finish;

  assign finish = sram_done_i || uart_done_i || decerr_i;

  always_comb begin
    if (sram_done_i) begin
      res_d = sram_result_i;
    end else if (uart_done_i) begin
      res_d = uart_result_i;
    end else begin
      res_d.data     = '0;
      res_d.resp     = RESP_DECERR;
      res_d.is_write = decerr_write_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
    end else if (finish) begin
      r_valid_o <= !res_d.is_write;
      b_valid_o <= res_d.is_write;
    end else begin
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
      end
    end
  end

  // held until the next finish, which cannot come before the handshake
  always_ff @(posedge clk) begin
    if (finish) begin
      res_q <= res_d;
    end
  end

  assign r_resp_o.data = res_q.data;
  assign r_resp_o.resp = res_q.resp;
  assign b_resp_o      = res_q.resp;
  assign resp_done_o   = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);

endmodule

// File: verilog/soc_periph_top.sv
module soc_periph_top (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                ar_valid_i,
  input  bus_pkg::addr_t      ar_addr_i,
  output logic                ar_ready_o,
  input  logic                aw_valid_i,
  input  bus_pkg::write_req_t aw_req_i,
  output logic                aw_ready_o,
  output logic                r_valid_o,
  output bus_pkg::read_resp_t r_resp_o,
  input  logic                r_ready_i,
  output logic                b_valid_o,
  output bus_pkg::resp_t      b_resp_o,
  input  logic                b_ready_i,
  output logic                tx_valid_o,
  output logic [7:0]          tx_byte_o
);
  import bus_pkg::*;

  bus_req_t     req;
  exec_result_t sram_result;
  exec_result_t uart_result;
  logic         sram_go;
  logic         uart_go;
  logic         sram_done;
  logic         uart_done;
  logic         decerr;
  logic         resp_done;

  bus_decode u_decode (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ar_valid_i  (ar_valid_i),
    .ar_addr_i   (ar_addr_i),
    .ar_ready_o  (ar_ready_o),
    .aw_valid_i  (aw_valid_i),
    .aw_req_i    (aw_req_i),
    .aw_ready_o  (aw_ready_o),
    .req_o       (req),
    .sram_go_o   (sram_go),
    .uart_go_o   (uart_go),
    .sram_done_i (sram_done),
    .uart_done_i (uart_done),
    .decerr_o    (decerr),
    .resp_done_i (resp_done)
  );

  sram_slave u_sram (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .go_i     (sram_go),
    .req_i    (req),
    .done_o   (sram_done),
    .result_o (sram_result)
  );

  uart_slave u_uart (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .go_i       (uart_go),
    .req_i      (req),
    .done_o     (uart_done),
    .result_o   (uart_result),
    .tx_valid_o (tx_valid_o),
    .tx_byte_o  (tx_byte_o)
  );

  bus_response u_response (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sram_done_i    (sram_done),
    .uart_done_i    (uart_done),
    .sram_result_i  (sram_result),
    .uart_result_i  (uart_result),
    .decerr_i       (decerr),
    .decerr_write_i (req.is_write),
    .r_valid_o      (r_valid_o),
    .r_resp_o       (r_resp_o),
    .r_ready_i      (r_ready_i),
    .b_valid_o      (b_valid_o),
    .b_resp_o       (b_resp_o),
    .b_ready_i      (b_ready_i),
    .resp_done_o    (resp_done)
  );

endmodule

// File: verification/soc_tb.sv
module soc_tb;
  import bus_pkg::*;
  import soc_map_pkg::*;

  localparam int          TIMEOUT   = 200;  // cycles per wait
  localparam string       TEST_FILE = "verification/soc_tests.txt";
  localparam logic [31:0] SEED      = 32'hde43_876d;

  logic       clk;
  logic       rst_n_i;
  logic       ar_valid_i;
  addr_t      ar_addr_i;
  logic       ar_ready_o;
  logic       aw_valid_i;
  write_req_t aw_req_i;
  logic       aw_ready_o;
  logic       r_valid_o;
  read_resp_t r_resp_o;
  logic       r_ready_i;
  logic       b_valid_o;
  resp_t      b_resp_o;
  logic       b_ready_i;
  logic       tx_valid_o;
  logic [7:0] tx_byte_o;

  logic [7:0] exp_byte;  // byte expected on the uart port for the current line
  int         tx_seen;

  soc_periph_top UUT (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ar_valid_i (ar_valid_i),
    .ar_addr_i  (ar_addr_i),
    .ar_ready_o (ar_ready_o),
    .aw_valid_i (aw_valid_i),
    .aw_req_i   (aw_req_i),
    .aw_ready_o (aw_ready_o),
    .r_valid_o  (r_valid_o),
    .r_resp_o   (r_resp_o),
    .r_ready_i  (r_ready_i),
    .b_valid_o  (b_valid_o),
    .b_resp_o   (b_resp_o),
    .b_ready_i  (b_ready_i),
    .tx_valid_o (tx_valid_o),
    .tx_byte_o  (tx_byte_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_run($sformatf("error %s: got 0x%08h, expected 0x%08h", name, got, expected));
    end
  endtask

  // counts uart strobes and checks each byte
  always @(negedge clk) begin
    if (tx_valid_o === 1'b1) begin
      tx_seen = tx_seen + 1;
      check_value("tx_byte_o", 32'(tx_byte_o), 32'(exp_byte));
    end
  end

  task automatic wait_request_ready(input logic is_write);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while ((is_write ? aw_ready_o : ar_ready_o) !== 1'b1) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT) begin
        stop_run("timeout: the request was never accepted");
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_response();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (r_valid_o !== 1'b1 && b_valid_o !== 1'b1) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT) begin
        stop_run("timeout: no response came back");
      end
      @(negedge clk);
    end
  endtask

  // response must not move and no new request may get in
  task automatic check_held(input logic is_write, input read_resp_t r_held,
                            input resp_t b_held);
    if (is_write) begin
      check_value("b_valid_o", 32'(b_valid_o), 32'd1);
      check_value("b_resp_o", 32'(b_resp_o), 32'(b_held));
    end else begin
      check_value("r_valid_o", 32'(r_valid_o), 32'd1);
      check_value("r_resp_o.data", r_resp_o.data, r_held.data);
      check_value("r_resp_o.resp", 32'(r_resp_o.resp), 32'(r_held.resp));
    end
    check_value("ar_ready_o", 32'(ar_ready_o), 32'd0);
    check_value("aw_ready_o", 32'(aw_ready_o), 32'd0);
  endtask

  task automatic run_line(input logic [7:0] op, input addr_t addr, input data_t wdata,
                          input strb_t strb, input data_t exp_rdata, input resp_t exp_resp);
    logic       is_write;
    logic       is_tx;
    int         tx_before;
    int         hold;
    read_resp_t r_held;
    resp_t      b_held;
    is_write  = (op == "W");
    is_tx     = is_write && (addr == UART_BASE + UART_TX_OFS);
    exp_byte  = wdata[7:0];
    tx_before = tx_seen;
    @(posedge clk);
    #1;
    if (is_write) begin
      aw_valid_i    = 1'b1;
      aw_req_i.addr = addr;
      aw_req_i.data = wdata;
      aw_req_i.strb = strb;
    end else begin
      ar_valid_i = 1'b1;
      ar_addr_i  = addr;
    end
    wait_request_ready(is_write);
    @(posedge clk);  // request handshake
    #1;
    ar_valid_i = 1'b0;
    aw_valid_i = 1'b0;
    wait_response();
    if (is_write) begin
      check_value("r_valid_o", 32'(r_valid_o), 32'd0);
    end else begin
      check_value("b_valid_o", 32'(b_valid_o), 32'd0);
    end
    r_held = r_resp_o;
    b_held = b_resp_o;
    hold   = $urandom % 4;
    repeat (hold) begin
      @(negedge clk);
      check_held(is_write, r_held, b_held);
    end
    @(posedge clk);
    #1;
    r_ready_i = !is_write;
    b_ready_i = is_write;
    @(negedge clk);
    check_held(is_write, r_held, b_held);
    @(posedge clk);  // response handshake
    #1;
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    if (is_write) begin
      check_value("b_resp_o", 32'(b_held), 32'(exp_resp));
    end else begin
      check_value("r_resp_o.data", r_held.data, exp_rdata);
      check_value("r_resp_o.resp", 32'(r_held.resp), 32'(exp_resp));
    end
    check_value("tx_valid_o strobes", tx_seen - tx_before, is_tx ? 32'd1 : 32'd0);
  endtask

  initial begin
    int         fd;
    int         c;
    int         n;
    int         lines;
    logic [7:0] op;
    addr_t      addr;
    data_t      wdata;
    strb_t      strb;
    data_t      exp_rdata;
    resp_t      exp_resp;
    rst_n_i    = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    aw_valid_i = 1'b0;
    aw_req_i   = '0;
    r_ready_i  = 1'b0;
    b_ready_i  = 1'b0;
    exp_byte   = 8'h00;
    tx_seen    = 0;
    lines      = 0;
    void'($urandom(SEED));
    repeat (2) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk);
    check_value("r_valid_o", 32'(r_valid_o), 32'd0);
    check_value("b_valid_o", 32'(b_valid_o), 32'd0);
    check_value("tx_valid_o", 32'(tx_valid_o), 32'd0);
    check_value("ar_ready_o", 32'(ar_ready_o), 32'd1);
    check_value("aw_ready_o", 32'(aw_ready_o), 32'd1);
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      stop_run("cannot open the test vector file");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == 35) begin  // '#' starts a comment line
        while (c != -1 && c != 10) begin
          c = $fgetc(fd);
        end
      end else if (c != 32 && c != 9 && c != 10 && c != 13) begin
        op = c[7:0];
        n  = $fscanf(fd, "%h %h %h %h %h", addr, wdata, strb, exp_rdata, exp_resp);
        if (n != 5 || (op != "R" && op != "W")) begin
          stop_run("malformed line in the test vector file");
        end
        run_line(op, addr, wdata, strb, exp_rdata, exp_resp);
        lines = lines + 1;
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    $display("%0d transactions checked", lines);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: verification/soc_tests.txt
# op addr wdata strb exp_rdata exp_resp, all hex, op is R or W
# resp 0 okay, 2 slverr, 3 decerr; wdata and strb are unused on reads
R 10000004 00000000 0 00000000 0
W 80000000 deadbeef f 00000000 0
R 80000000 00000000 0 deadbeef 0
W 80000004 12345678 f 00000000 0
W 800003fc a5a5a5a5 f 00000000 0
R 80000004 00000000 0 12345678 0
R 800003fc 00000000 0 a5a5a5a5 0
W 80000000 000000aa 1 00000000 0
R 80000000 00000000 0 deadbeaa 0
W 80000000 11223344 6 00000000 0
R 80000000 00000000 0 de2233aa 0
W 80000004 ff00ff00 8 00000000 0
R 80000004 00000000 0 ff345678 0
W 10000000 00000048 f 00000000 0
W 10000000 00000169 f 00000000 0
R 10000004 00000000 0 00000002 0
W 10000004 00000055 f 00000000 2
R 10000000 00000000 0 00000000 0
R 00000000 00000000 0 00000000 3
W 20000000 12345678 f 00000000 3
R 80000400 00000000 0 00000000 3
R 10000008 00000000 0 00000000 3
W 10000000 0000007e 1 00000000 0
R 10000004 00000000 0 00000003 0
R 7ffffffc 00000000 0 00000000 3

// File: compile.f
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/bus_decode.sv
verilog/sram_slave.sv
verilog/uart_slave.sv
verilog/bus_response.sv
verilog/soc_periph_top.sv
verification/soc_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := soc_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
